// ==== rtl/link_pkg.sv ====
// shared link types and default widths, imported by the link control and the testbench
package link_pkg;

   //##############################
   // default geometry
   //##############################

   // core side packet width in bits
   parameter int PW_DEFAULT  = 104;

   // half of one io beat, so a beat is 2*IOW bits
   parameter int IOW_DEFAULT = 16;

   //##############################
   // sequencer state
   //##############################

   // one encoding for both sequencers
   // start is only visited by the transmit side
   typedef enum logic [1:0] {
      idle  = 2'b00,   // waiting for a request or a start beat
      start = 2'b01,   // start beat on the io bus
      busy  = 2'b10    // data beats moving
   } link_state_t;

   // beats per packet is configured at run time
   // legal range is 1 to ceil(PW / (2*IOW)), so 4 with the defaults

endpackage

// ==== rtl/link_ctrl.sv ====
// transmit and receive sequencers of the link, instantiated once by io_link
`timescale 1ns/1ps

module link_ctrl #(
   parameter int  PW  = link_pkg::PW_DEFAULT,   // core packet width
   parameter int  IOW = link_pkg::IOW_DEFAULT,  // half beat width
   localparam int CW  = $clog2(2*PW/IOW)        // beat counter width
) (
   input  logic          clk,
   input  logic          nreset,        // async, active low
   input  logic [CW-1:0] datasize,      // beats per packet
   input  logic          tx_access,     // core request, held until tx_wait falls
   input  logic          io_rx_access,  // start beat marker from the io bus
   output logic          tx_wait,       // transmitter not ready
   output logic          tx_load,       // capture core packet
   output logic          tx_shift,      // advance serializer one beat
   output logic          io_tx_access,  // start beat marker to the io bus
   output logic          rx_clear,      // wipe deserializer at start beat
   output logic          rx_shift,      // capture one io beat
   output logic          rx_access      // one cycle pulse, packet complete
);
   import link_pkg::*;

   link_state_t   tx_state;
   link_state_t   rx_state;
   logic [CW-1:0] tx_count;   // data beats still to send
   logic [CW-1:0] rx_count;   // data beats still to take
   logic          tx_last;    // final data beat is on the wire
   logic          rx_done;    // all beats taken

   //##############################
   // transmit sequencer
   //##############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         tx_state <= idle;
      end else begin
         case (tx_state)
            idle: begin
               if (tx_access) begin
                  tx_state <= start;   // accept, tx_wait rises next cycle
               end
            end
            start: tx_state <= busy;   // one start beat only
            busy: begin
               if (tx_last) begin
                  tx_state <= idle;
               end
            end
            default: tx_state <= idle;
         endcase
      end
   end

   // reloads every idle cycle, so the accept edge picks up datasize
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         tx_count <= '0;
      end else if (tx_state == idle) begin
         tx_count <= datasize;
      end else if (tx_state == busy) begin
         tx_count <= tx_count - 1'b1;
      end
   end

   // count of one or zero ends the frame, zero only for an illegal datasize
   assign tx_last      = (tx_state == busy) & ~|tx_count[CW-1:1];
   assign tx_wait      = (tx_state != idle);
   assign tx_load      = tx_access & (tx_state == idle);  // ignored while waiting
   assign tx_shift     = (tx_state == busy);
   assign io_tx_access = (tx_state == start);

   //##############################
   // receive sequencer
   //##############################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_state <= idle;
      end else begin
         case (rx_state)
            idle:    rx_state <= io_rx_access ? busy : idle;
            busy:    rx_state <= rx_done ? idle : busy;
            default: rx_state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_count <= '0;
      end else if (rx_state == busy) begin
         rx_count <= rx_count - 1'b1;
      end else begin
         rx_count <= datasize;   // armed for the next start beat
      end
   end

   assign rx_done  = (rx_state == busy) & ~|rx_count;
   assign rx_shift = (rx_state == busy) & ~rx_done;      // d captures per frame
   assign rx_clear = io_rx_access & (rx_state == idle);  // start beat seen

   // delayed done becomes the fifo strobe
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_access <= 1'b0;
      end else begin
         rx_access <= rx_done;
      end
   end

endmodule

// ==== rtl/tx_serializer.sv ====
// transmit datapath that cuts a core packet into io beats, top beat first
`timescale 1ns/1ps

module tx_serializer #(
   parameter int  PW  = link_pkg::PW_DEFAULT,   // core packet width
   parameter int  IOW = link_pkg::IOW_DEFAULT,  // half beat width
   localparam int CW  = $clog2(2*PW/IOW)        // datasize width
) (
   input  logic           clk,
   input  logic           tx_load,       // capture on accept
   input  logic           tx_shift,      // next beat
   input  logic [CW-1:0]  datasize,      // beats per packet
   input  logic [PW-1:0]  tx_packet,     // core packet
   output logic [2*IOW-1:0] io_tx_packet // current beat
);

   localparam int BW = 2*IOW;            // beat width
   localparam int NB = (PW + BW - 1)/BW; // beats in a full packet
   localparam int SW = NB*BW;            // register width, whole beats

   logic [SW-1:0] shreg;    // outgoing beats, next one at the top
   logic [SW-1:0] aligned;  // packet with beat d-1 moved to the top

   //##############################
   // alignment on load
   //##############################

   // short packets move up by the unused beats, so beat d-1 leads
   // beats above d-1 fall off the top and never reach the wire
   always_comb begin
      aligned = SW'(tx_packet) << (BW * (NB - datasize));
   end

   //##############################
   // beat shifter
   //##############################

   // load on accept, then one beat per data cycle
   always_ff @(posedge clk) begin
      if (tx_load) begin
         shreg <= aligned;
      end else if (tx_shift) begin
         shreg <= shreg << BW;   // toward lower order beats
      end
   end

   // during the start beat this already shows beat d-1, receiver ignores it
   assign io_tx_packet = shreg[SW-1 -: BW];

endmodule

// ==== rtl/rx_deserializer.sv ====
// receive datapath that rebuilds the wide packet from io beats for the core fifo
`timescale 1ns/1ps

module rx_deserializer #(
   parameter int PW  = link_pkg::PW_DEFAULT,   // core packet width, above one beat
   parameter int IOW = link_pkg::IOW_DEFAULT   // half beat width
) (
   input  logic             clk,
   input  logic             nreset,        // async, active low
   input  logic             rx_clear,      // start beat, wipe old packet
   input  logic             rx_shift,      // take one beat
   input  logic [2*IOW-1:0] io_rx_packet,  // beat from the io bus
   output logic [PW-1:0]    rx_packet      // reassembled packet
);

   localparam int BW = 2*IOW;   // beat width

   //##############################
   // packet assembly
   //##############################

   // first beat ends up highest after d shifts
   // unsent upper beats stay zero from the clear
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rx_packet <= '0;
      end else if (rx_clear) begin
         rx_packet <= '0;
      end else if (rx_shift) begin
         // new beat in at the bottom, bits past PW fall off the top
         rx_packet <= {rx_packet[PW-BW-1:0], io_rx_packet};
      end
   end

   // clear and shift never overlap
   // clear comes from the idle sequencer, shift from the busy one
   // packet then holds until the next start beat
   // fifo samples it with rx_access

endmodule

// ==== rtl/io_link.sv ====
// top level of the narrow packet link, joins the sequencers with both datapaths
`timescale 1ns/1ps

module io_link #(
   parameter int  PW  = link_pkg::PW_DEFAULT,   // core packet width
   parameter int  IOW = link_pkg::IOW_DEFAULT,  // half beat width
   localparam int CW  = $clog2(2*PW/IOW)        // datasize width
) (
   input  logic             clk,
   input  logic             nreset,         // async, active low
   input  logic [CW-1:0]    datasize,       // beats per packet, 1 to ceil(PW/(2*IOW))
   // core transmit side
   input  logic             tx_access,
   input  logic [PW-1:0]    tx_packet,
   output logic             tx_wait,
   // io bus out
   output logic             io_tx_access,   // high on the start beat
   output logic [2*IOW-1:0] io_tx_packet,
   // io bus in
   input  logic             io_rx_access,
   input  logic [2*IOW-1:0] io_rx_packet,
   // core receive fifo side, no back pressure
   output logic             rx_access,
   output logic [PW-1:0]    rx_packet
);

   logic tx_load;    // accept strobe
   logic tx_shift;   // serializer advance
   logic rx_clear;   // start beat seen
   logic rx_shift;   // beat capture

   //##############################
   // sequencing
   //##############################

   link_ctrl #(.PW(PW), .IOW(IOW)) ctrl_i (
      .clk          (clk),
      .nreset       (nreset),
      .datasize     (datasize),
      .tx_access    (tx_access),
      .io_rx_access (io_rx_access),
      .tx_wait      (tx_wait),
      .tx_load      (tx_load),
      .tx_shift     (tx_shift),
      .io_tx_access (io_tx_access),
      .rx_clear     (rx_clear),
      .rx_shift     (rx_shift),
      .rx_access    (rx_access)
   );

   //##############################
   // datapaths
   //##############################

   tx_serializer #(.PW(PW), .IOW(IOW)) ser_i (
      .clk          (clk),
      .tx_load      (tx_load),
      .tx_shift     (tx_shift),
      .datasize     (datasize),
      .tx_packet    (tx_packet),
      .io_tx_packet (io_tx_packet)
   );

   rx_deserializer #(.PW(PW), .IOW(IOW)) deser_i (
      .clk          (clk),
      .nreset       (nreset),
      .rx_clear     (rx_clear),
      .rx_shift     (rx_shift),
      .io_rx_packet (io_rx_packet),
      .rx_packet    (rx_packet)
   );

endmodule

// ==== verification/io_link_sva.sv ====
// link timing assertions, bound into io_link by the testbench
`timescale 1ns/1ps

module io_link_sva #(
   parameter int  PW  = link_pkg::PW_DEFAULT,
   parameter int  IOW = link_pkg::IOW_DEFAULT,
   localparam int CW  = $clog2(2*PW/IOW)
) (
   input logic          clk,
   input logic          nreset,
   input logic [CW-1:0] datasize,
   input logic          tx_shift,      // high while the transmit machine is busy
   input logic          io_tx_access,
   input logic          io_rx_access,
   input logic          rx_access
);

   logic [CW:0] due_count;   // cycles left until rx_access
   logic        armed;       // frame in flight on the receive side
   logic        due;

   // reload on a start beat once the previous frame has come due
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         due_count <= '0;
         armed     <= 1'b0;
      end else if (io_rx_access && (!armed || due_count == '0)) begin
         due_count <= {1'b0, datasize} + 1'b1;
         armed     <= 1'b1;
      end else if (armed) begin
         if (due_count == '0) begin
            armed <= 1'b0;
         end else begin
            due_count <= due_count - 1'b1;
         end
      end
   end

   assign due = armed & (due_count == '0);

   rx_pulse_a: assert property (@(posedge clk) disable iff (!nreset)
      rx_access |=> !rx_access) else $error("rx_access held longer than one cycle");

   // one start beat, then the machine is busy with data beats
   start_beat_a: assert property (@(posedge clk) disable iff (!nreset)
      io_tx_access |=> tx_shift) else $error("start beat not followed by data beats");

   rx_latency_a: assert property (@(posedge clk) disable iff (!nreset)
      rx_access == due) else $error("rx_access not d+2 cycles after start beat");

endmodule

bind io_link io_link_sva #(.PW(PW), .IOW(IOW)) sva_i (
   .clk          (clk),
   .nreset       (nreset),
   .datasize     (datasize),
   .tx_shift     (tx_shift),
   .io_tx_access (io_tx_access),
   .io_rx_access (io_rx_access),
   .rx_access    (rx_access)
);

// ==== verification/io_link_tb.sv ====
// loopback testbench for the packet link, runs directed tests and prints one result line
`timescale 1ns/1ps

module io_link_tb;
   import link_pkg::*;

   localparam int PW        = PW_DEFAULT;
   localparam int IOW       = IOW_DEFAULT;
   localparam int BW        = 2*IOW;             // beat width
   localparam int CW        = $clog2(2*PW/IOW);  // datasize width
   localparam int MAX_D     = (PW + BW - 1)/BW;  // beats in a full packet
   localparam int N_PACKETS = 14;                // 1 + 4 + 8 + 1 over all tests
   localparam int LIMIT     = 50*N_PACKETS + 20; // timeout in cycles, reset included

   logic          clk;
   logic          nreset;
   logic [CW-1:0] datasize;
   logic          tx_access;
   logic [PW-1:0] tx_packet;
   logic          tx_wait;
   logic          io_tx_access;
   logic [BW-1:0] io_tx_packet;
   logic          io_rx_access;
   logic [BW-1:0] io_rx_packet;
   logic          rx_access;
   logic [PW-1:0] rx_packet;

   logic [PW-1:0] exp_q[$];      // expected packets in order
   logic [31:0]   rng_state;
   int            errors;
   int            cycles;
   int            wait_run;      // tx_wait high cycles in the current frame
   int            rx_pulses;

   io_link #(.PW(PW), .IOW(IOW)) dut_i (.*);

   // io bus loopback
   assign io_rx_access = io_tx_access;
   assign io_rx_packet = io_tx_packet;

   always #10 clk = ~clk;   // 20 ns period

   //##############################
   // helpers
   //##############################

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // 104 bits from four random words
   task automatic random_packet(output logic [PW-1:0] p);
      logic [127:0] w;
      for (int i = 0; i < 4; i++) begin
         rng_state = xorshift32(rng_state);
         w[i*32 +: 32] = rng_state;
      end
      p = w[PW-1:0];
   endtask

   // frame rule, low d beats survive and the rest reads zero
   function automatic logic [PW-1:0] expected_packet(input logic [PW-1:0] p, input int d);
      logic [PW-1:0] e;
      for (int i = 0; i < PW; i++) begin
         e[i] = (i < d*BW) ? p[i] : 1'b0;
      end
      return e;
   endfunction

   task automatic compare_packet(input logic [PW-1:0] act, input logic [PW-1:0] exp);
      if (act !== exp) begin
         $display("Mismatch at %0t: rx_packet got %h expected %h", $time, act, exp);
         errors++;
      end
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, act, exp);
         errors++;
      end
   endtask

   task automatic compare_count(input string name, input int act, input int exp);
      if (act != exp) begin
         $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, act, exp);
         errors++;
      end
   endtask

   // returns on the rising edge that accepts the held request
   task automatic wait_accept();
      @(negedge clk);
      while (tx_wait) @(negedge clk);
      @(posedge clk);
   endtask

   // present one packet, hold until taken, then drop the request
   task automatic send_packet(input logic [PW-1:0] p);
      @(posedge clk);
      tx_access <= 1'b1;
      tx_packet <= p;
      wait_accept();
      exp_q.push_back(expected_packet(p, int'(datasize)));
      tx_access <= 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(negedge clk);
      repeat (3) @(negedge clk);
   endtask

   task automatic set_datasize(input int d);
      @(posedge clk);
      datasize <= CW'(d);
   endtask

   //##############################
   // monitors
   //##############################

   always @(negedge clk) begin
      if (nreset && rx_access) begin
         rx_pulses++;
         if (exp_q.size() == 0) begin
            $display("rx_access pulsed at %0t with no packet outstanding", $time);
            errors++;
         end else begin
            compare_packet(rx_packet, exp_q.pop_front());
         end
      end
   end

   // every frame keeps tx_wait high for d+1 cycles
   always @(negedge clk) begin
      if (tx_wait) begin
         wait_run++;
      end else if (wait_run != 0) begin
         compare_count("tx_wait high cycles", wait_run, int'(datasize) + 1);
         wait_run = 0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout after %0d cycles, an rx_access pulse never arrived", cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   //##############################
   // directed tests
   //##############################

   task automatic test_reset_state();
      compare_bit("tx_wait", tx_wait, 1'b0);
      compare_bit("io_tx_access", io_tx_access, 1'b0);
      compare_bit("rx_access", rx_access, 1'b0);
   endtask

   // start beat in cycle 1, rx_access in cycle d+3
   task automatic test_single_full();
      logic [PW-1:0] p;
      int n;
      set_datasize(MAX_D);
      random_packet(p);
      send_packet(p);
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (n == 1) begin
            compare_bit("io_tx_access", io_tx_access, 1'b1);
            compare_bit("tx_wait", tx_wait, 1'b1);
         end
      end while (!rx_access && n < 40);
      compare_count("rx_access latency", n, MAX_D + 3);
      wait_drain();
   endtask

   task automatic test_every_datasize();
      logic [PW-1:0] p;
      for (int d = 1; d <= MAX_D; d++) begin
         set_datasize(d);
         random_packet(p);
         send_packet(p);
         wait_drain();
      end
   endtask

   // request stays high across tx_wait, new packet on each accept
   task automatic test_back_to_back();
      logic [PW-1:0] p;
      int start_pulses;
      set_datasize(MAX_D);
      start_pulses = rx_pulses;
      @(posedge clk);
      for (int i = 0; i < 8; i++) begin
         random_packet(p);
         tx_access <= 1'b1;
         tx_packet <= p;
         wait_accept();
         exp_q.push_back(expected_packet(p, MAX_D));
      end
      tx_access <= 1'b0;
      wait_drain();
      compare_count("rx_access pulses", rx_pulses - start_pulses, 8);
   endtask

   // a short request during tx_wait must not start a frame
   task automatic test_ignored_request();
      logic [PW-1:0] p;
      int start_pulses;
      start_pulses = rx_pulses;
      random_packet(p);
      send_packet(p);
      @(posedge clk);
      tx_access <= 1'b1;
      @(posedge clk);
      tx_access <= 1'b0;
      wait_drain();
      repeat (10) @(negedge clk);
      compare_count("rx_access pulses", rx_pulses - start_pulses, 1);
      compare_bit("tx_wait", tx_wait, 1'b0);
   endtask

   //##############################
   // main sequence
   //##############################

   initial begin
      clk       = 1'b0;
      nreset    = 1'b0;
      datasize  = CW'(MAX_D);
      tx_access = 1'b0;
      tx_packet = '0;
      rng_state = 32'h626e_588b;
      errors    = 0;
      cycles    = 0;
      wait_run  = 0;
      rx_pulses = 0;
      repeat (10) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      test_reset_state();
      test_single_full();
      test_every_datasize();
      test_back_to_back();
      test_ignored_request();
      $display("errors: %0d, packets left over: %0d", errors, exp_q.size());
      if (errors == 0 && exp_q.size() == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== project.f ====
rtl/link_pkg.sv
rtl/link_ctrl.sv
rtl/tx_serializer.sv
rtl/rx_deserializer.sv
rtl/io_link.sv
verification/io_link_sva.sv
verification/io_link_tb.sv

// ==== Makefile ====
TOP = io_link_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
